// File: rtl/main_cfg.svh
`ifndef MAIN_CFG_SVH
`define MAIN_CFG_SVH

// External ROM address width, 128 KB
`define MAIN_ROM_AW 17

// Graphics fetch address, upper half of ROM
`define MAIN_GFX_AW 16

// Work RAM address width, 4 KB
`define MAIN_RAM_AW 12

// Offset of the first banked page
`define MAIN_BANK_BASE 4

// Value read back from unmapped space
`define MAIN_OPEN_BUS 8'hFF

`endif

// File: rtl/main_pkg.sv
`default_nettype none

// Shared types for the main CPU subsystem
package main_pkg;

    // Decoded target of the current CPU address
    typedef enum logic [2:0] {
        REG_NONE      = 3'd0, // Unmapped, reads as open bus
        REG_ROM_FIXED = 3'd1, // 8000-FFFF
        REG_ROM_BANK  = 3'd2, // 6000-7FFF, reads only
        REG_RAM       = 3'd3, // 1000-1FFF
        REG_IO        = 3'd4  // 0000-03FF
    } region_t;

    // Owner of the external ROM port
    typedef enum logic [1:0] {
        REQ_IDLE = 2'd0,
        REQ_CPU  = 2'd1, // Program fetch
        REQ_GFX  = 2'd2  // Tile fetch
    } rom_req_t;

endpackage

`default_nettype wire

// File: rtl/main_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "main_cfg.svh"

// Address map decode and CPU read data mux
module main_decoder (
    input  wire logic [15:0]      cpu_addr,
    input  wire logic             cpu_rnw,
    input  wire logic [7:0]       io_data,      // Registered input port
    input  wire logic [7:0]       ram_data,
    input  wire logic [7:0]       rom_data_cpu, // From the arbiter
    output main_pkg::region_t     region,
    output logic      [7:0]       cpu_din,
    output logic                  bank_we,      // Not yet qualified by cpu_cen
    output logic                  out_we
);

    logic rom_fixed_hit;
    logic rom_bank_hit;
    logic ram_hit;
    logic io_hit;

    // ROM space only answers reads
    assign rom_fixed_hit = cpu_addr[15] && cpu_rnw;              // 8000-FFFF
    assign rom_bank_hit  = cpu_addr[15:13] == 3'b011 && cpu_rnw; // 6000-7FFF
    assign ram_hit       = cpu_addr[15:12] == 4'b0001;           // 1000-1FFF
    assign io_hit        = cpu_addr[15:10] == 6'b0000_00;        // 0000-03FF

    always_comb begin
        if (rom_fixed_hit) begin
            region = main_pkg::REG_ROM_FIXED;
        end else if (rom_bank_hit) begin
            region = main_pkg::REG_ROM_BANK;
        end else if (ram_hit) begin
            region = main_pkg::REG_RAM;
        end else if (io_hit) begin
            region = main_pkg::REG_IO; // Writes here also end a bus cycle
        end else begin
            region = main_pkg::REG_NONE; // Video, palette and gaps
        end
    end

    // Bank register sits under the banked window on writes
    assign bank_we = cpu_addr[15:12] == 4'b0111 && !cpu_rnw; // 7000-7FFF

    // Output ports at 0018-001F
    assign out_we = cpu_addr[15:3] == 13'h0003 && !cpu_rnw;

    always_comb begin
        case (region)
            main_pkg::REG_ROM_FIXED,
            main_pkg::REG_ROM_BANK: cpu_din = rom_data_cpu;
            main_pkg::REG_RAM:      cpu_din = ram_data;
            main_pkg::REG_IO:       cpu_din = io_data;
            default:                cpu_din = `MAIN_OPEN_BUS;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/main_io.sv
`timescale 1ns/1ps
`default_nettype none

// Cabinet input ports, bank register and sound CPU interface
module main_io (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        cpu_cen,      // One cycle bus strobe
    input  wire logic [15:0] cpu_addr,
    input  wire logic [7:0]  cpu_dout,
    input  wire logic        bank_we,
    input  wire logic        out_we,
    input  wire logic [1:0]  start_button,
    input  wire logic [1:0]  coin_input,
    input  wire logic        service,
    input  wire logic [5:0]  joystick1,
    input  wire logic [5:0]  joystick2,
    input  wire logic [7:0]  dipsw_a,
    input  wire logic [7:0]  dipsw_b,
    input  wire logic [3:0]  dipsw_c,
    input  wire logic        snd_ack,
    output logic      [7:0]  io_data,
    output logic      [3:0]  bank,
    output logic             snd_irq,
    output logic      [7:0]  snd_latch
);

    // Input port follows the low address bits, one cycle behind
    always_ff @(posedge clk) begin
        case (cpu_addr[2:0])
            3'b000:  io_data <= {3'b111, start_button, service, coin_input};
            3'b001:  io_data <= {2'b11, joystick1};
            3'b010:  io_data <= {2'b11, joystick2};
            3'b100:  io_data <= dipsw_a;
            3'b101:  io_data <= dipsw_b;
            3'b110:  io_data <= {4'hF, dipsw_c};
            default: io_data <= io_data; // 3 and 7 are not wired
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bank      <= 4'd0;
            snd_irq   <= 1'b0;
            snd_latch <= 8'd0;
        end else begin
            // Sound CPU acknowledge drops the request
            if (snd_ack) begin
                snd_irq <= 1'b0;
            end
            if (cpu_cen && bank_we) begin
                bank <= cpu_dout[3:0]; // Upper data bits ignored
            end
            if (cpu_cen && out_we) begin
                case (cpu_addr[2:1])
                    2'b01:   snd_irq   <= 1'b1;     // 001A/001B, wins over ack
                    2'b10:   snd_latch <= cpu_dout; // 001C/001D
                    default: ;                      // Coin counters, not used
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/work_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "main_cfg.svh"

// CPU work RAM, written on the clock, read combinationally
module work_ram (
    input  wire logic                    clk,
    input  wire logic                    we,
    input  wire logic [`MAIN_RAM_AW-1:0] addr,
    input  wire logic [7:0]              din,
    output logic      [7:0]              dout
);

    localparam int DEPTH = 1 << `MAIN_RAM_AW; // 4096 bytes

    logic [7:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
        end
    end

    // Same cycle read, so a write shows on the next access
    assign dout = mem[addr];

endmodule

`default_nettype wire

// File: rtl/rom_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "main_cfg.svh"

// Shares the external ROM between CPU program fetch and tile fetch
module rom_arbiter (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    cpu_req,
    input  wire logic [`MAIN_ROM_AW-1:0] cpu_addr,
    input  wire logic                    gfx_req,
    input  wire logic [`MAIN_GFX_AW-1:0] gfx_addr,
    input  wire logic [7:0]              rom_data,
    input  wire logic                    rom_ok,
    output logic                         cpu_ok,
    output logic                         gfx_ok,
    output logic      [7:0]              cpu_data,
    output logic      [7:0]              gfx_data,
    output logic      [`MAIN_ROM_AW-1:0] rom_addr,
    output logic                         rom_cs
);

    main_pkg::rom_req_t state;

    logic                    cpu_valid; // cpu_data holds the byte at cpu_last
    logic                    gfx_valid;
    logic [`MAIN_ROM_AW-1:0] cpu_last;

    // A new CPU address invalidates the served byte at once
    assign cpu_ok = cpu_valid && cpu_req && cpu_addr == cpu_last;
    assign gfx_ok = gfx_valid && gfx_req;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= main_pkg::REQ_IDLE;
            rom_cs    <= 1'b0;
            cpu_valid <= 1'b0;
            gfx_valid <= 1'b0;
        end else begin
            if (!cpu_req) cpu_valid <= 1'b0; // Request released
            if (!gfx_req) gfx_valid <= 1'b0;
            case (state)
                main_pkg::REQ_IDLE: begin
                    // CPU first, one idle cycle between transfers
                    if (cpu_req && !cpu_ok) begin
                        state     <= main_pkg::REQ_CPU;
                        rom_addr  <= cpu_addr;
                        cpu_last  <= cpu_addr;
                        cpu_valid <= 1'b0;
                        rom_cs    <= 1'b1;
                    end else if (gfx_req && !gfx_valid) begin
                        state    <= main_pkg::REQ_GFX;
                        rom_addr <= {1'b1, gfx_addr}; // Upper ROM half
                        rom_cs   <= 1'b1;
                    end
                end
                main_pkg::REQ_CPU: begin
                    if (rom_ok) begin // Address held until here
                        cpu_data  <= rom_data;
                        cpu_valid <= 1'b1;
                        rom_cs    <= 1'b0;
                        state     <= main_pkg::REQ_IDLE;
                    end
                end
                main_pkg::REQ_GFX: begin
                    if (rom_ok) begin
                        gfx_data  <= rom_data;
                        gfx_valid <= 1'b1;
                        rom_cs    <= 1'b0;
                        state     <= main_pkg::REQ_IDLE;
                    end
                end
                default: begin
                    rom_cs <= 1'b0;
                    state  <= main_pkg::REQ_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/main_board.sv
`timescale 1ns/1ps
`default_nettype none

`include "main_cfg.svh"

// Main CPU side of the board, CPU core sits outside
module main_board (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic [15:0]             cpu_addr,
    input  wire logic                    cpu_rnw,
    input  wire logic [7:0]              cpu_dout,
    input  wire logic                    cpu_cen,
    output logic      [7:0]              cpu_din,
    output logic                         cpu_ok,
    input  wire logic [1:0]              start_button,
    input  wire logic [1:0]              coin_input,
    input  wire logic                    service,
    input  wire logic [5:0]              joystick1,
    input  wire logic [5:0]              joystick2,
    input  wire logic [7:0]              dipsw_a,
    input  wire logic [7:0]              dipsw_b,
    input  wire logic [3:0]              dipsw_c,
    input  wire logic                    snd_ack,
    output logic                         snd_irq,
    output logic      [7:0]              snd_latch,
    input  wire logic [`MAIN_GFX_AW-1:0] gfx_addr,
    input  wire logic                    gfx_cs,
    output logic                         gfx_ok,
    output logic      [7:0]              gfx_data,
    output logic      [`MAIN_ROM_AW-1:0] rom_addr,
    output logic                         rom_cs,
    input  wire logic [7:0]              rom_data,
    input  wire logic                    rom_ok
);

    main_pkg::region_t region;

    logic [7:0]              io_data;
    logic [7:0]              ram_data;
    logic [7:0]              rom_data_cpu;
    logic                    bank_we;
    logic                    out_we;
    logic [3:0]              bank;
    logic [3:0]              bank_page; // Bank plus base offset
    logic                    ram_we;
    logic                    rom_hit;
    logic                    rom_cpu_ok;
    logic [`MAIN_ROM_AW-1:0] cpu_rom_addr;
    logic [15:0]             addr_last;

    assign bank_page = bank + 4'(`MAIN_BANK_BASE);
    assign rom_hit   = region == main_pkg::REG_ROM_FIXED || region == main_pkg::REG_ROM_BANK;

    // Fixed ROM is the first 32 KB, banks are 8 KB pages
    assign cpu_rom_addr = region == main_pkg::REG_ROM_FIXED ?
                          {{(`MAIN_ROM_AW-15){1'b0}}, cpu_addr[14:0]} :
                          {bank_page, cpu_addr[12:0]};

    assign ram_we = region == main_pkg::REG_RAM && cpu_cen && !cpu_rnw;

    // Local targets are ready once the address has crossed an edge
    always_ff @(posedge clk) begin
        addr_last <= cpu_addr;
    end

    assign cpu_ok = rom_hit ? rom_cpu_ok : addr_last == cpu_addr;

    main_decoder main_decoder_i (
        .cpu_addr, .cpu_rnw, .io_data, .ram_data, .rom_data_cpu,
        .region, .cpu_din, .bank_we, .out_we
    );

    main_io main_io_i (
        .clk, .rst, .cpu_cen, .cpu_addr, .cpu_dout, .bank_we, .out_we,
        .start_button, .coin_input, .service, .joystick1, .joystick2,
        .dipsw_a, .dipsw_b, .dipsw_c, .snd_ack,
        .io_data, .bank, .snd_irq, .snd_latch
    );

    work_ram work_ram_i (
        .clk,
        .we   (ram_we),
        .addr (cpu_addr[`MAIN_RAM_AW-1:0]),
        .din  (cpu_dout),
        .dout (ram_data)
    );

    rom_arbiter rom_arbiter_i (
        .clk, .rst,
        .cpu_req  (rom_hit),
        .cpu_addr (cpu_rom_addr),
        .gfx_req  (gfx_cs),
        .gfx_addr, .rom_data, .rom_ok,
        .cpu_ok   (rom_cpu_ok),
        .gfx_ok,
        .cpu_data (rom_data_cpu),
        .gfx_data, .rom_addr, .rom_cs
    );

endmodule

`default_nettype wire

// File: test/main_board_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "main_cfg.svh"

module main_board_tb;

    localparam int MAX_CASES = 64;

    logic                    clk;
    logic                    rst;
    logic [15:0]             cpu_addr;
    logic                    cpu_rnw;
    logic [7:0]              cpu_dout;
    logic                    cpu_cen;
    logic [7:0]              cpu_din;
    logic                    cpu_ok;
    logic [1:0]              start_button;
    logic [1:0]              coin_input;
    logic                    service;
    logic [5:0]              joystick1;
    logic [5:0]              joystick2;
    logic [7:0]              dipsw_a;
    logic [7:0]              dipsw_b;
    logic [3:0]              dipsw_c;
    logic                    snd_ack;
    logic                    snd_irq;
    logic [7:0]              snd_latch;
    logic [`MAIN_GFX_AW-1:0] gfx_addr;
    logic                    gfx_cs;
    logic                    gfx_ok;
    logic [7:0]              gfx_data;
    logic [`MAIN_ROM_AW-1:0] rom_addr;
    logic                    rom_cs;
    logic [7:0]              rom_data;
    logic                    rom_ok;

    // ROM model state
    logic [7:0]              lfsr;
    logic [1:0]              lat_bits;
    logic [2:0]              rom_wait;
    logic                    rom_busy;
    logic [`MAIN_ROM_AW-1:0] rom_held; // Address taken when rom_cs rose

    // Case table, filled from the case file
    logic [3:0]  case_op   [MAX_CASES];
    logic [15:0] case_addr [MAX_CASES];
    logic [15:0] case_data [MAX_CASES];
    logic [7:0]  case_exp  [MAX_CASES];
    int          n_cases;
    logic        cases_loaded;
    int          fail_count;
    int          rom_errors;
    logic        case_bad;
    logic [3:0]  bank_seen; // Bank as the testbench expects it

    main_board main_board_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 125 MHz
    end

    // Galois LFSR, taps for x^8+x^6+x^5+x^4+1
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
    endfunction

    // ROM content rule
    function automatic logic [7:0] rom_byte(input logic [`MAIN_ROM_AW-1:0] a);
        return a[7:0] ^ a[16:9];
    endfunction

    function automatic logic is_rom(input logic [15:0] a);
        return a[15] || a[15:13] == 3'b011; // Fixed or banked window
    endfunction

    // Where the memory map puts a CPU ROM read
    function automatic logic [`MAIN_ROM_AW-1:0] expected_rom_addr(input logic [15:0] a,
                                                                   input logic [3:0] bank);
        if (a[15]) return {2'b00, a[14:0]};
        return {bank + 4'(`MAIN_BANK_BASE), a[12:0]};
    endfunction

    // ROM model, answers each rom_cs after 1 to 4 cycles
    initial begin
        rom_ok   <= 1'b0;
        rom_data <= 8'h00;
        rom_busy <= 1'b0;
        rom_wait <= 3'd0;
        rom_held <= '0;
        lfsr = 8'd62;
        forever begin
            @(posedge clk);
            rom_ok <= 1'b0; // One cycle pulse
            if (rst) begin
                rom_busy <= 1'b0;
            end else if (rom_busy) begin
                if (rom_addr != rom_held) begin
                    $display("Error at %0d ns: rom_addr moved from %h to %h before rom_ok",
                             $time, rom_held, rom_addr);
                    rom_errors++;
                end
                if (rom_wait == 3'd1) begin
                    rom_ok   <= 1'b1;
                    rom_data <= rom_byte(rom_held);
                    rom_busy <= 1'b0;
                end else begin
                    rom_wait <= rom_wait - 3'd1;
                end
            end else if (rom_cs && !rom_ok) begin
                lat_bits[0] = lfsr[0]; // One step per latency bit
                lfsr = lfsr_next(lfsr);
                lat_bits[1] = lfsr[0];
                lfsr = lfsr_next(lfsr);
                rom_wait <= {1'b0, lat_bits} + 3'd1;
                rom_held <= rom_addr;
                rom_busy <= 1'b1;
            end
        end
    end

    // Every cabinet and DIP input follows one pattern byte
    task automatic apply_inputs(input logic [7:0] p);
        start_button <= p[1:0];
        coin_input   <= p[3:2];
        service      <= p[4];
        joystick1    <= p[7:2];
        joystick2    <= p[5:0] ^ 6'h2A;
        dipsw_a      <= p;
        dipsw_b      <= ~p;
        dipsw_c      <= p[7:4];
    endtask

    task automatic report_mismatch(input string what, input logic [15:0] a,
                                   input logic [7:0] got, input logic [7:0] exp);
        $display("Error at %0d ns: %s at %h returned %h, expected %h", $time, what, a, got, exp);
        case_bad = 1'b1;
    endtask

    task automatic bus_read(input logic [15:0] a, input logic [7:0] p, output logic [7:0] d);
        @(posedge clk);
        cpu_addr <= a;
        cpu_rnw  <= 1'b1;
        cpu_cen  <= 1'b1;
        apply_inputs(p);
        @(posedge clk);
        cpu_cen <= 1'b0;
        @(posedge clk); // Address and inputs have crossed an edge
        while (!cpu_ok) @(posedge clk);
        d = cpu_din;
        cpu_addr <= 16'h4000; // Park on open bus
    endtask

    task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
        @(posedge clk);
        cpu_addr <= a;
        cpu_rnw  <= 1'b0;
        cpu_dout <= d;
        cpu_cen  <= 1'b1;
        @(posedge clk); // Write lands here
        cpu_cen  <= 1'b0;
        cpu_rnw  <= 1'b1;
        cpu_addr <= 16'h4000;
    endtask

    // Tile fetch, optionally racing a CPU ROM read
    task automatic rom_fetch(input logic use_cpu, input logic [15:0] a, input logic [15:0] g,
                             output logic [7:0] cd, output logic [7:0] gd);
        logic cpu_done;
        logic gfx_done;
        cpu_done = !use_cpu;
        gfx_done = 1'b0;
        cd = 8'h00;
        gd = 8'h00;
        @(posedge clk);
        if (use_cpu) cpu_addr <= a;
        gfx_addr <= g;
        gfx_cs   <= 1'b1;
        while (!(cpu_done && gfx_done)) begin
            @(posedge clk);
            if (!cpu_done && cpu_ok) begin
                cd = cpu_din;
                cpu_done = 1'b1;
                cpu_addr <= 16'h4000; // Release the CPU request
            end
            if (!gfx_done && gfx_ok) begin
                gd = gfx_data;
                gfx_done = 1'b1;
                gfx_cs <= 1'b0;
            end
        end
    endtask

    task automatic apply_reset(input int cycles);
        @(posedge clk);
        rst <= 1'b1;
        repeat (cycles) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic load_cases();
        int    fd;
        int    f_op;
        int    f_addr;
        int    f_data;
        int    f_exp;
        int    cnt;
        string line;
        cnt = 0;
        fd = $fopen("test/main_board_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file test/main_board_cases.txt");
        end else begin
            while (!$feof(fd) && cnt < MAX_CASES) begin
                if ($fgets(line, fd) > 0 &&
                    $sscanf(line, "%h %h %h %h", f_op, f_addr, f_data, f_exp) == 4) begin
                    case_op[cnt]   = f_op[3:0];
                    case_addr[cnt] = f_addr[15:0];
                    case_data[cnt] = f_data[15:0];
                    case_exp[cnt]  = f_exp[7:0];
                    cnt++;
                end
            end
            $fclose(fd);
        end
        n_cases = cnt;
    endtask

    task automatic run_case(input int i);
        logic [15:0] a;
        logic [7:0]  got;
        logic [7:0]  exp;
        logic [7:0]  got_gfx;
        logic [7:0]  exp_gfx;
        a = case_addr[i];
        exp = case_exp[i];
        case_bad = 1'b0;
        case (case_op[i])
            4'h1: begin
                bus_read(a, case_data[i][7:0], got);
                if (is_rom(a)) exp = rom_byte(expected_rom_addr(a, bank_seen));
                if (got != exp) report_mismatch("read", a, got, exp);
            end
            4'h2: begin
                bus_write(a, case_data[i][7:0]);
                if (a[15:12] == 4'h7) bank_seen = case_data[i][3:0]; // Bank register
            end
            4'h3: begin
                rom_fetch(1'b0, 16'h4000, a, got, got_gfx);
                exp_gfx = rom_byte({1'b1, a}); // Upper ROM half
                if (got_gfx != exp_gfx) report_mismatch("gfx fetch", a, got_gfx, exp_gfx);
            end
            4'h4: begin
                rom_fetch(1'b1, a, case_data[i], got, got_gfx);
                exp = rom_byte(expected_rom_addr(a, bank_seen));
                exp_gfx = rom_byte({1'b1, case_data[i]});
                if (got != exp) report_mismatch("read", a, got, exp);
                if (got_gfx != exp_gfx) begin
                    report_mismatch("gfx fetch", case_data[i], got_gfx, exp_gfx);
                end
            end
            4'h5: begin
                @(posedge clk);
                if (snd_latch != exp) report_mismatch("snd_latch", a, snd_latch, exp);
            end
            4'h6: begin
                @(posedge clk);
                if (snd_irq != exp[0]) report_mismatch("snd_irq", a, {7'd0, snd_irq}, exp);
            end
            4'h7: begin
                @(posedge clk);
                snd_ack <= 1'b1;
                @(posedge clk);
                snd_ack <= 1'b0;
            end
            4'h8: begin
                apply_reset(2);
                bank_seen = 4'd0;
            end
            default: begin
                $display("Case %0d has an unknown operation code %0h", i, case_op[i]);
                case_bad = 1'b1;
            end
        endcase
        if (case_bad) begin
            fail_count++;
            $display("Case %0d op %0h addr %h failed", i, case_op[i], a);
        end else begin
            $display("Case %0d op %0h addr %h passed", i, case_op[i], a);
        end
    endtask

    // Watchdog sized from the case count
    initial begin
        wait (cases_loaded);
        #((n_cases * 20 + 8) * 8);
        $display("Timeout: the cases did not finish within the time limit");
        $display("Test FAILED");
        $finish;
    end

    initial begin
        rst      <= 1'b1;
        cpu_addr <= 16'h4000;
        cpu_rnw  <= 1'b1;
        cpu_dout <= 8'h00;
        cpu_cen  <= 1'b0;
        snd_ack  <= 1'b0;
        gfx_addr <= '0;
        gfx_cs   <= 1'b0;
        apply_inputs(8'h00);
        bank_seen = 4'd0;
        load_cases();
        cases_loaded = 1'b1;
        if (n_cases == 0) begin
            $display("No cases were read from the case file");
        end else begin
            repeat (8) @(posedge clk);
            rst <= 1'b0;
            for (int i = 0; i < n_cases; i++) begin
                run_case(i);
            end
        end
        $display("Cases run: %0d, failed: %0d, ROM port errors: %0d",
                 n_cases, fail_count, rom_errors);
        if (n_cases > 0 && fail_count == 0 && rom_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/main_board_cases.txt
# Columns: op addr data expected, all hex. op 1 read (data = cabinet input pattern),
# 2 write, 3 tile fetch (addr = tile address), 4 CPU read plus tile fetch (data = tile
# address), 5 check snd_latch, 6 check snd_irq, 7 pulse snd_ack, 8 mid-run reset.
# ROM reads carry 00 as expected value, the testbench works out the ROM byte.
1 0000 0000 E0
1 0001 0000 C0
1 0002 0000 EA
1 0004 0000 00
1 0005 0000 FF
1 0006 0000 F0
1 0000 005A F6
1 0001 005A D6
1 0002 005A F0
1 0006 005A F5
1 0208 00C3 F8
1 03FC 00C3 C3
1 0005 00C3 3C
1 8000 0000 00
1 9A5C 0000 00
2 7000 0003 00
1 6000 0000 00
1 7FFF 0000 00
2 7ABC 00F9 00
1 6123 0000 00
2 1000 0011 00
2 1ABC 00A7 00
1 1000 0000 11
1 1ABC 0000 A7
1 2000 0000 FF
1 0400 0000 FF
1 5FFF 0000 FF
2 001C 0096 00
5 0000 0000 96
2 001A 0000 00
6 0000 0000 01
7 0000 0000 00
6 0000 0000 00
3 1234 0000 00
4 8765 4321 00
4 6ABC 0F0F 00
2 001A 0000 00
8 0000 0000 00
6 0000 0000 00
5 0000 0000 00
1 6000 0000 00

// File: vlog.f
+incdir+rtl
rtl/main_pkg.sv
rtl/main_decoder.sv
rtl/main_io.sv
rtl/work_ram.sv
rtl/rom_arbiter.sv
rtl/main_board.sv
test/main_board_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the main board testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f vlog.f --top-module main_board_tb -Mdir obj_dir

./obj_dir/Vmain_board_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test OK" sim.log; then
    exit 0
fi
exit 1
